// ==== build.f ====
+incdir+bench
verilog/imgproc_pkg.sv
verilog/stream_stage.sv
verilog/pixel_position.sv
verilog/pixel_shader.sv
verilog/box_tracker.sv
verilog/control_regs.sv
verilog/imgproc.sv
bench/tb_imgproc.sv

// ==== Makefile ====
TOP = tb_imgproc

.PHONY: all sim lint clean

all: sim

# Build and run, the exit status carries pass or fail
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f build.f -o V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

// ==== bench/tb_imgproc_tasks.svh ====
// Every task starts and returns just after a rising edge

task automatic apply_reset();
	reset_n <= 1'b0;
	repeat (2) @(posedge clk);
	reset_n <= 1'b1;
	got_q.delete();
endtask

task automatic write_register(input logic [2:0] addr, input logic [31:0] data);
	s_chipselect <= 1'b1;
	s_write      <= 1'b1;
	s_address    <= addr;
	s_writedata  <= data;
	@(posedge clk);
	s_chipselect <= 1'b0;
	s_write      <= 1'b0;
endtask

task automatic read_register(input logic [2:0] addr, output logic [31:0] data);
	s_chipselect <= 1'b1;
	s_read       <= 1'b1;
	s_address    <= addr;
	@(posedge clk);                                  // Read data loads on this edge
	s_chipselect <= 1'b0;
	s_read       <= 1'b0;
	@(negedge clk);
	data = s_readdata;
	@(posedge clk);
endtask

// Sink driver that samples ready mid-cycle where it is stable
task automatic send_packet();
	logic took;
	for (int i = 0; i < FRAME_BEATS; i++) begin
		sink_valid <= 1'b1;
		sink_data  <= frame_buf[i];
		sink_sop   <= (i == 0);
		sink_eop   <= (i == FRAME_BEATS - 1);
		took = 1'b0;
		while (!took) begin
			@(negedge clk);
			took = sink_ready;
			@(posedge clk);
		end
	end
	sink_valid <= 1'b0;
	sink_sop   <= 1'b0;
	sink_eop   <= 1'b0;
endtask

// Records each source transfer, which completes on the next edge
initial forever begin
	@(negedge clk);
	if (source_valid && source_ready)
		got_q.push_back({6'b0, source_data, source_sop, source_eop});
end

////////////////////////////////////////////////////////////////////////////
// Reference model

function automatic imgproc_pkg::pixel_t expected_pixel(input imgproc_pkg::pixel_t p,
		input int x, input int y);
	int g;
	if (ref_found && (x == ref_left || x == ref_right || y == ref_top || y == ref_bottom))
		return ref_colour;
	if (p.red[7] && p.green[7] && p.blue[7])
		return 24'hff_ffff;                      // Bright pixel
	g = int'(p.green) / 2 + int'(p.red) / 4 + int'(p.blue) / 4;
	return {g[7:0], g[7:0], g[7:0]};
endfunction

task automatic expect_frame(input logic mode_on);
	logic                rewrite;
	imgproc_pkg::pixel_t pix;
	exp_q.delete();
	for (int i = 0; i < FRAME_BEATS; i++) begin
		rewrite = mode_on && i > 0 && frame_buf[0].blue[3:0] == 4'h0;
		pix = rewrite ? expected_pixel(frame_buf[i], (i - 1) % IMAGE_W, (i - 1) / IMAGE_W)
			: frame_buf[i];
		exp_q.push_back({6'b0, pix, i == 0, i == FRAME_BEATS - 1});
	end
endtask

// Hashed pixels, or a dark frame with three bright spots
task automatic fill_frame(input logic [3:0] packet_type, input logic spots);
	logic [31:0] h;
	frame_buf[0] = {20'h8a5c3, packet_type};             // Upper bits differ from their grey
	for (int i = 1; i < FRAME_BEATS; i++) begin
		h = i * 32'h9e37_79b9;
		frame_buf[i] = spots ? 24'h20_4060 : h[31:8];
	end
	if (spots) begin
		frame_buf[1 + 2 * IMAGE_W + 3]  = 24'hc0_e0f0;     // x 3, y 2
		frame_buf[1 + 5 * IMAGE_W + 11] = 24'hc0_e0f0;     // x 11, y 5
		frame_buf[1 + 6 * IMAGE_W + 7]  = 24'hff_8080;     // x 7, y 6
	end
endtask

task automatic run_frame(input string name, input logic mode_on);
	mode <= mode_on;
	expect_frame(mode_on);
	got_q.delete();
	send_packet();
	while (got_q.size() < FRAME_BEATS)
		@(negedge clk);
	repeat (4) @(posedge clk);                    // Catch any extra beat
	check_value({name, " beat count"}, FRAME_BEATS, got_q.size());
	for (int i = 0; i < FRAME_BEATS; i++)
		check_value(name, exp_q[i], got_q[i]);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic registers_readback();
	logic [31:0] word;
	apply_reset();
	read_register(imgproc_pkg::ADDR_STATUS, word);
	check_value("registers status", 32'h0000_0000, word);
	read_register(imgproc_pkg::ADDR_ID, word);
	check_value("registers id", imgproc_pkg::DEVICE_ID, word);
	read_register(imgproc_pkg::ADDR_BOX_COLOUR, word);
	check_value("registers colour default", 32'h0000_ff00, word);
	write_register(imgproc_pkg::ADDR_BOX_COLOUR, 32'hdec0_ffee);
	read_register(imgproc_pkg::ADDR_BOX_COLOUR, word);
	check_value("registers colour write", 32'h00c0_ffee, word);
	read_register(3'd7, word);
	check_value("registers unmapped", 32'h0000_0000, word);
endtask

task automatic passthrough_mode_low();
	apply_reset();
	ref_found = 1'b0;
	fill_frame(4'h0, 1'b0);
	run_frame("passthrough", 1'b0);
endtask

task automatic non_video_unchanged();
	logic [31:0] word;
	apply_reset();
	ref_found = 1'b0;
	fill_frame(4'h5, 1'b0);
	run_frame("non video", 1'b1);
	read_register(imgproc_pkg::ADDR_STATUS, word);
	check_value("non video status", 32'h0000_0000, word);
endtask

task automatic highlight_first_frame();
	apply_reset();
	ref_found = 1'b0;
	fill_frame(4'h0, 1'b0);
	run_frame("highlight", 1'b1);
endtask

task automatic box_find_and_overlay();
	logic [31:0] word;
	apply_reset();
	write_register(imgproc_pkg::ADDR_BOX_COLOUR, 32'h00ff_00ff);
	ref_found  = 1'b0;
	ref_colour = 24'hff_00ff;
	fill_frame(4'h0, 1'b1);
	run_frame("box first frame", 1'b1);
	read_register(imgproc_pkg::ADDR_BOX_X, word);
	check_value("box x", 32'h000b_0003, word);      // Right 11, left 3
	read_register(imgproc_pkg::ADDR_BOX_Y, word);
	check_value("box y", 32'h0006_0002, word);      // Bottom 6, top 2
	read_register(imgproc_pkg::ADDR_STATUS, word);
	check_value("box status", 32'h0000_0101, word);
	ref_found  = 1'b1;
	ref_left   = 3;
	ref_right  = 11;
	ref_top    = 2;
	ref_bottom = 6;
	fill_frame(4'h0, 1'b0);
	run_frame("box overlay", 1'b1);
endtask

task automatic random_backpressure();
	apply_reset();
	ref_found = 1'b0;
	fill_frame(4'h0, 1'b0);
	random_ready = 1'b1;
	run_frame("backpressure", 1'b1);
	random_ready = 1'b0;
endtask

// ==== bench/tb_imgproc.sv ====
`timescale 1ns/10ps

module tb_imgproc;

	localparam int IMAGE_W     = 16;
	localparam int IMAGE_H     = 8;
	localparam int FRAME_BEATS = IMAGE_W * IMAGE_H + 1;        // Descriptor plus pixels
	localparam int CLK_PERIOD  = 40;
	localparam int WATCHDOG_NS = 6 * FRAME_BEATS * 8 * CLK_PERIOD;

	logic                clk;
	logic                reset_n;
	imgproc_pkg::pixel_t sink_data;
	logic                sink_valid;
	logic                sink_ready;
	logic                sink_sop;
	logic                sink_eop;
	imgproc_pkg::pixel_t source_data;
	logic                source_valid;
	logic                source_ready;
	logic                source_sop;
	logic                source_eop;
	logic                mode;
	logic                s_chipselect;
	logic                s_read;
	logic                s_write;
	logic [2:0]          s_address;
	logic [31:0]         s_writedata;
	logic [31:0]         s_readdata;

	// Beats as {6'b0, pixel, sop, eop}
	logic [31:0]         exp_q[$];
	logic [31:0]         got_q[$];
	imgproc_pkg::pixel_t frame_buf [0:FRAME_BEATS-1];

	logic                random_ready = 1'b0;
	integer              seed = 32'h6c3b;
	logic [31:0]         rnd;

	// Box state that the reference model draws with
	int                  ref_left, ref_right, ref_top, ref_bottom;
	logic                ref_found;
	imgproc_pkg::pixel_t ref_colour;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	imgproc #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata)
	);

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	`include "tb_imgproc_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// Downstream ready is random only during the back-pressure test

	initial begin
		source_ready <= 1'b0;
		forever begin
			@(posedge clk);
			if (random_ready) begin
				rnd = $random(seed);
				source_ready <= rnd[0];
			end else
				source_ready <= 1'b1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("Result: FAILED");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		reset_n      <= 1'b0;
		sink_data    <= '0;
		sink_valid   <= 1'b0;
		sink_sop     <= 1'b0;
		sink_eop     <= 1'b0;
		mode         <= 1'b0;
		s_chipselect <= 1'b0;
		s_read       <= 1'b0;
		s_write      <= 1'b0;
		s_address    <= 3'd0;
		s_writedata  <= 32'h0;
		registers_readback();
		passthrough_mode_low();
		non_video_unchanged();
		highlight_first_frame();
		box_find_and_overlay();
		random_backpressure();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== verilog/imgproc.sv ====
`timescale 1ns/10ps

module imgproc #(
	parameter int                  IMAGE_W            = 640,
	parameter int                  IMAGE_H            = 480,
	parameter imgproc_pkg::pixel_t BOX_COLOUR_DEFAULT = 24'h00_ff00
) (
	input  logic                clk,
	input  logic                reset_n,

	// Stream sink
	input  imgproc_pkg::pixel_t sink_data,
	input  logic                sink_valid,
	output logic                sink_ready,
	input  logic                sink_sop,
	input  logic                sink_eop,

	// Stream source
	output imgproc_pkg::pixel_t source_data,
	output logic                source_valid,
	input  logic                source_ready,
	output logic                source_sop,
	output logic                source_eop,

	input  logic                mode,

	// Memory-mapped slave
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  logic [2:0]          s_address,
	input  logic [31:0]         s_writedata,
	output logic [31:0]         s_readdata
);

	logic [imgproc_pkg::BEAT_W-1:0] in_beat, mid_beat, out_beat;
	logic                in_valid, out_ready, accept;
	imgproc_pkg::pixel_t in_pixel, shaded_pixel, box_colour;
	logic                in_sop, in_eop;
	imgproc_pkg::coord_t x, y;
	logic                packet_video, bright;
	imgproc_pkg::coord_t box_left, box_right, box_top, box_bottom;
	logic                box_found;
	logic [7:0]          frame_count;

	////////////////////////////////////////////////////////////////////////////
	// Stream path

	stream_stage #(.WIDTH(imgproc_pkg::BEAT_W)) in_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (sink_valid),
		.in_ready  (sink_ready),
		.in_data   ({sink_data, sink_sop, sink_eop}),
		.out_valid (in_valid),
		.out_ready (out_ready),
		.out_data  (in_beat)
	);

	assign {in_pixel, in_sop, in_eop} = in_beat;
	assign accept   = in_valid & out_ready;        // Beat crosses between the stages
	assign mid_beat = {shaded_pixel, in_sop, in_eop};

	stream_stage #(.WIDTH(imgproc_pkg::BEAT_W)) out_stage (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (in_valid),
		.in_ready  (out_ready),
		.in_data   (mid_beat),
		.out_valid (source_valid),
		.out_ready (source_ready),
		.out_data  (out_beat)
	);

	assign {source_data, source_sop, source_eop} = out_beat;

	////////////////////////////////////////////////////////////////////////////
	// Processing

	pixel_position #(.IMAGE_W(IMAGE_W)) u_position (
		.clk          (clk),
		.reset_n      (reset_n),
		.accept       (accept),
		.sop          (in_sop),
		.blue_low     (in_pixel.blue[3:0]),
		.x            (x),
		.y            (y),
		.packet_video (packet_video)
	);

	pixel_shader u_shader (
		.pixel        (in_pixel),
		.x            (x),
		.y            (y),
		.mode         (mode),
		.sop          (in_sop),
		.packet_video (packet_video),
		.box_left     (box_left),
		.box_right    (box_right),
		.box_top      (box_top),
		.box_bottom   (box_bottom),
		.box_found    (box_found),
		.box_colour   (box_colour),
		.bright       (bright),
		.pixel_out    (shaded_pixel)
	);

	box_tracker #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) u_tracker (
		.clk          (clk),
		.reset_n      (reset_n),
		.accept       (accept),
		.sop          (in_sop),
		.eop          (in_eop),
		.bright       (bright),
		.packet_video (packet_video),
		.x            (x),
		.y            (y),
		.box_left     (box_left),
		.box_right    (box_right),
		.box_top      (box_top),
		.box_bottom   (box_bottom),
		.box_found    (box_found),
		.frame_count  (frame_count)
	);

	control_regs #(.BOX_COLOUR_DEFAULT(BOX_COLOUR_DEFAULT)) u_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.s_readdata   (s_readdata),
		.box_left     (box_left),
		.box_right    (box_right),
		.box_top      (box_top),
		.box_bottom   (box_bottom),
		.box_found    (box_found),
		.frame_count  (frame_count),
		.box_colour   (box_colour)
	);

endmodule

// ==== verilog/control_regs.sv ====
`timescale 1ns/10ps

module control_regs #(
	parameter imgproc_pkg::pixel_t BOX_COLOUR_DEFAULT = 24'h00_ff00
) (
	input  logic                clk,
	input  logic                reset_n,

	// Memory-mapped slave
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  logic [2:0]          s_address,
	input  logic [31:0]         s_writedata,
	output logic [31:0]         s_readdata,

	// Tracker results
	input  imgproc_pkg::coord_t box_left,
	input  imgproc_pkg::coord_t box_right,
	input  imgproc_pkg::coord_t box_top,
	input  imgproc_pkg::coord_t box_bottom,
	input  logic                box_found,
	input  logic [7:0]          frame_count,

	output imgproc_pkg::pixel_t box_colour
);

	logic [31:0] read_word;

	////////////////////////////////////////////////////////////////////////////
	// Writes land on the edge they are sampled

	always_ff @(posedge clk) begin
		if (!reset_n)
			box_colour <= BOX_COLOUR_DEFAULT;
		else if (s_chipselect && s_write && s_address == imgproc_pkg::ADDR_BOX_COLOUR)
			box_colour <= s_writedata[23:0];
	end

	// Read mux
	always_comb begin
		case (s_address)
			imgproc_pkg::ADDR_STATUS:
				read_word = {16'h0000, frame_count, 7'b0, box_found};
			imgproc_pkg::ADDR_ID:
				read_word = imgproc_pkg::DEVICE_ID;
			imgproc_pkg::ADDR_BOX_COLOUR:
				read_word = {8'h00, box_colour};
			imgproc_pkg::ADDR_BOX_X:
				read_word = {5'b0, box_right, 5'b0, box_left};
			imgproc_pkg::ADDR_BOX_Y:
				read_word = {5'b0, box_bottom, 5'b0, box_top};
			default:
				read_word = 32'h0000_0000;    // Unmapped
		endcase
	end

	// Read data valid one cycle after the request and held until the next read
	always_ff @(posedge clk) begin
		if (!reset_n)
			s_readdata <= 32'h0000_0000;
		else if (s_chipselect && s_read)
			s_readdata <= read_word;
	end

endmodule

// ==== verilog/box_tracker.sv ====
`timescale 1ns/10ps

module box_tracker #(
	parameter int IMAGE_W = 640,
	parameter int IMAGE_H = 480
) (
	input  logic                clk,
	input  logic                reset_n,

	input  logic                accept,
	input  logic                sop,
	input  logic                eop,
	input  logic                bright,
	input  logic                packet_video,
	input  imgproc_pkg::coord_t x,
	input  imgproc_pkg::coord_t y,

	// Box of the last completed video frame
	output imgproc_pkg::coord_t box_left,
	output imgproc_pkg::coord_t box_right,
	output imgproc_pkg::coord_t box_top,
	output imgproc_pkg::coord_t box_bottom,
	output logic                box_found,
	output logic [7:0]          frame_count
);

	localparam imgproc_pkg::coord_t X_EMPTY = imgproc_pkg::coord_t'(IMAGE_W - 1);
	localparam imgproc_pkg::coord_t Y_EMPTY = imgproc_pkg::coord_t'(IMAGE_H - 1);

	imgproc_pkg::coord_t x_min, x_max, y_min, y_max;
	imgproc_pkg::coord_t x_min_nxt, x_max_nxt, y_min_nxt, y_max_nxt;
	logic                seen, seen_nxt;
	logic                hit;
	logic                frame_end;

	////////////////////////////////////////////////////////////////////////////
	// Running bounds including the current beat

	assign hit = accept & ~sop & packet_video & bright;

	assign x_min_nxt = (hit && x < x_min) ? x : x_min;
	assign x_max_nxt = (hit && x > x_max) ? x : x_max;
	assign y_min_nxt = (hit && y < y_min) ? y : y_min;
	assign y_max_nxt = (hit && y > y_max) ? y : y_max;
	assign seen_nxt  = seen | hit;

	// Last pixel of a video frame, the descriptor never counts as one
	assign frame_end = accept & eop & ~sop & packet_video;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x_min <= X_EMPTY;
			x_max <= '0;
			y_min <= Y_EMPTY;
			y_max <= '0;
			seen  <= 1'b0;
		end else if (accept) begin
			if (sop) begin                   // New packet starts with an empty box
				x_min <= X_EMPTY;
				x_max <= '0;
				y_min <= Y_EMPTY;
				y_max <= '0;
				seen  <= 1'b0;
			end else begin
				x_min <= x_min_nxt;
				x_max <= x_max_nxt;
				y_min <= y_min_nxt;
				y_max <= y_max_nxt;
				seen  <= seen_nxt;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Latched box, shown on the frames that follow

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			box_left    <= '0;
			box_right   <= '0;
			box_top     <= '0;
			box_bottom  <= '0;
			box_found   <= 1'b0;
			frame_count <= 8'd0;
		end else if (frame_end) begin
			box_left    <= x_min_nxt;
			box_right   <= x_max_nxt;
			box_top     <= y_min_nxt;
			box_bottom  <= y_max_nxt;
			box_found   <= seen_nxt;
			frame_count <= frame_count + 8'd1;    // Wraps at 256
		end
	end

endmodule

// ==== verilog/pixel_shader.sv ====
`timescale 1ns/10ps

module pixel_shader (
	input  imgproc_pkg::pixel_t pixel,
	input  imgproc_pkg::coord_t x,
	input  imgproc_pkg::coord_t y,
	input  logic                mode,
	input  logic                sop,
	input  logic                packet_video,

	// Box latched from the last finished frame
	input  imgproc_pkg::coord_t box_left,
	input  imgproc_pkg::coord_t box_right,
	input  imgproc_pkg::coord_t box_top,
	input  imgproc_pkg::coord_t box_bottom,
	input  logic                box_found,
	input  imgproc_pkg::pixel_t box_colour,

	output logic                bright,
	output imgproc_pkg::pixel_t pixel_out
);

	imgproc_pkg::channel_t grey;
	imgproc_pkg::pixel_t   highlight;
	imgproc_pkg::pixel_t   shaded;
	logic                  on_box;
	logic                  rewrite;

	// All three channels in their upper half
	assign bright = pixel.red[7] & pixel.green[7] & pixel.blue[7];

	// Grey = green/2 + red/4 + blue/4, peaks at 253 so no overflow
	assign grey = {1'b0, pixel.green[7:1]}
		+ {2'b00, pixel.red[7:2]}
		+ {2'b00, pixel.blue[7:2]};

	assign highlight = bright ? imgproc_pkg::WHITE : imgproc_pkg::pixel_t'({grey, grey, grey});

	// Box edges are drawn as full lines across the frame
	assign on_box = box_found &
		((x == box_left) | (x == box_right) | (y == box_top) | (y == box_bottom));

	assign shaded = on_box ? box_colour : highlight;

	// Descriptor beats and non-video packets are never touched
	assign rewrite = mode & ~sop & packet_video;

	assign pixel_out = rewrite ? shaded : pixel;

endmodule

// ==== verilog/pixel_position.sv ====
`timescale 1ns/10ps

module pixel_position #(
	parameter int IMAGE_W = 640
) (
	input  logic                clk,
	input  logic                reset_n,

	input  logic                accept,      // Beat moves to the output stage
	input  logic                sop,
	input  logic [3:0]          blue_low,    // Packet type nibble of the descriptor

	output imgproc_pkg::coord_t x,
	output imgproc_pkg::coord_t y,
	output logic                packet_video
);

	localparam imgproc_pkg::coord_t X_LAST = imgproc_pkg::coord_t'(IMAGE_W - 1);

	////////////////////////////////////////////////////////////////////////////
	// Raster counters
	//
	// The descriptor clears the position, so the first pixel after it is
	// seen at 0,0. Every later beat steps x and wraps into the next row.

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x            <= '0;
			y            <= '0;
			packet_video <= 1'b0;
		end else if (accept) begin
			if (sop) begin
				x            <= '0;
				y            <= '0;
				packet_video <= (blue_low == 4'h0);   // Type 0 is video
			end else if (x == X_LAST) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/stream_stage.sv ====
`timescale 1ns/10ps

module stream_stage #(
	parameter int WIDTH = 26
) (
	input  logic             clk,
	input  logic             reset_n,

	// Upstream side
	input  logic             in_valid,
	output logic             in_ready,
	input  logic [WIDTH-1:0] in_data,

	// Downstream side
	output logic             out_valid,
	input  logic             out_ready,
	output logic [WIDTH-1:0] out_data
);

	logic             full;
	logic [WIDTH-1:0] data_q;

	// Room for a new beat when empty or when the held one leaves this cycle
	assign in_ready = ~full | out_ready;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			full   <= 1'b0;
			data_q <= '0;
		end else if (in_ready) begin
			full <= in_valid;
			if (in_valid)
				data_q <= in_data;              // Only capture real beats
		end
	end

	assign out_valid = full;
	assign out_data  = data_q;

endmodule

// ==== verilog/imgproc_pkg.sv ====
package imgproc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Pixel and coordinate types

	localparam int COORD_W = 11;             // Up to 2047 pixels per line or row

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [7:0] channel_t;

	// Red sits in the top byte, blue in the bottom
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} pixel_t;

	// One stream beat is the pixel followed by the sop and eop marks
	localparam int BEAT_W = $bits(pixel_t) + 2;

	////////////////////////////////////////////////////////////////////////////
	// Register map of the memory-mapped port

	localparam logic [2:0] ADDR_STATUS     = 3'd0;
	localparam logic [2:0] ADDR_ID         = 3'd1;
	localparam logic [2:0] ADDR_BOX_COLOUR = 3'd2;
	localparam logic [2:0] ADDR_BOX_X      = 3'd3;  // Right in 26:16, left in 10:0
	localparam logic [2:0] ADDR_BOX_Y      = 3'd4;  // Bottom in 26:16, top in 10:0

	localparam logic [31:0] DEVICE_ID = 32'h1234_eee2;

	// Highlight for bright pixels
	localparam pixel_t WHITE = 24'hff_ffff;

endpackage
